/* hdl/apu_settings.svh */
`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// Status on read, channel enables on write.
`define APU_ADDR_STATUS 5'h15

// Frame counter control.
`define APU_ADDR_FRAME 5'h17

// Sequencer ticks between two frame steps.
`define APU_FRAME_STEP 3728

// Left shift applied to the sum of the channel samples.
`define APU_MIX_SHIFT 3

`endif

/* hdl/apu_bus_pkg.sv */
package apu_bus_pkg;

	// APB byte address.
	typedef logic [4:0] apb_addr_t;

	// APB register data.
	typedef logic [7:0] apb_data_t;

	// Register index inside one channel.
	typedef logic [1:0] chan_reg_t;

endpackage

/* hdl/apu_audio_pkg.sv */
package apu_audio_pkg;

	// Level of one channel.
	typedef logic [3:0] sample_t;

	// Mixed output.
	typedef logic [7:0] mix_t;

	typedef logic [10:0] timer_t;
	typedef logic [7:0] length_t;
	typedef logic [1:0] duty_t;

	// Frame sequencer steps.
	typedef enum logic [2:0] {
		FS_STEP1,
		FS_STEP2,
		FS_STEP3,
		FS_STEP4,
		FS_STEP5
	} frame_state_t;

endpackage

/* hdl/apu_regs.sv */
`timescale 1ns/100ps
`include "apu_settings.svh"

module apu_regs (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  apu_bus_pkg::apb_addr_t paddr,
	input  apu_bus_pkg::apb_data_t pwdata,
	input  logic                   irq_tick,
	input  logic                   act0,
	input  logic                   act1,
	output apu_bus_pkg::apb_data_t prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   wr0,
	output logic                   wr1,
	output apu_bus_pkg::chan_reg_t reg_idx,
	output apu_bus_pkg::apb_data_t wdata,
	output logic                   en0,
	output logic                   en1,
	output logic                   mode,
	output logic                   restart,
	output logic                   irq
);

	logic access;
	logic mapped;
	logic stat_rd;
	logic stat_wr;
	logic frame_wr;
	logic inhibit;
	logic [4:0] en;

	assign access = psel && penable;
	assign mapped = (paddr[4:3] == 2'b00) || (paddr == `APU_ADDR_STATUS) ||
		(paddr == `APU_ADDR_FRAME);

	assign pready = 1'b1;
	assign pslverr = access && !mapped;

	// Pulse 0 at 0x00-0x03, pulse 1 at 0x04-0x07.
	assign wr0 = access && pwrite && (paddr[4:2] == 3'd0);
	assign wr1 = access && pwrite && (paddr[4:2] == 3'd1);
	assign reg_idx = paddr[1:0];
	assign wdata = pwdata;

	assign stat_rd = access && !pwrite && (paddr == `APU_ADDR_STATUS);
	assign stat_wr = access && pwrite && (paddr == `APU_ADDR_STATUS);
	assign frame_wr = access && pwrite && (paddr == `APU_ADDR_FRAME);
	assign restart = frame_wr;

	assign prdata = stat_rd ? {1'b0, irq, 4'b0000, act1, act0} : 8'h00;

	// Triangle, noise and DMC enables are kept for readback-free software.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			en <= 5'b0;
		end else if (stat_wr) begin
			en <= pwdata[4:0];
		end
	end

	assign en0 = en[0];
	assign en1 = en[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			mode <= 1'b0;
			inhibit <= 1'b0;
		end else if (frame_wr) begin
			mode <= pwdata[7];
			inhibit <= pwdata[6];
		end
	end

	// Setting inhibit beats a tick in the same cycle.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			irq <= 1'b0;
		end else if (frame_wr && pwdata[6]) begin
			irq <= 1'b0;
		end else if (irq_tick && !mode && !inhibit) begin
			irq <= 1'b1;
		end else if (stat_rd) begin
			irq <= 1'b0;
		end
	end

	a_penable_psel: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		penable |-> psel);

	a_wr_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(wr0 && wr1));

endmodule

/* hdl/apu_frame_seq.sv */
`timescale 1ns/100ps
`include "apu_settings.svh"

module apu_frame_seq (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic mode,
	input  logic restart,
	output logic quarter,
	output logic half,
	output logic irq_tick
);

	logic phase;
	logic fire;
	logic [11:0] cnt;
	apu_audio_pkg::frame_state_t state;

	// Half-rate enable, realigned by a restart.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			phase <= 1'b0;
		end else if (restart) begin
			phase <= 1'b0;
		end else begin
			phase <= ~phase;
		end
	end

	assign fire = phase && (cnt == 12'(`APU_FRAME_STEP - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt <= 12'd0;
			state <= apu_audio_pkg::FS_STEP1;
			quarter <= 1'b0;
			half <= 1'b0;
			irq_tick <= 1'b0;
		end else if (restart) begin
			cnt <= 12'd0;
			state <= apu_audio_pkg::FS_STEP1;
			quarter <= 1'b0;
			half <= 1'b0;
			irq_tick <= 1'b0;
		end else begin
			quarter <= 1'b0;
			half <= 1'b0;
			irq_tick <= 1'b0;
			if (fire) begin
				cnt <= 12'd0;
				case (state)
					apu_audio_pkg::FS_STEP1: begin
						quarter <= 1'b1;
						state <= apu_audio_pkg::FS_STEP2;
					end
					apu_audio_pkg::FS_STEP2: begin
						quarter <= 1'b1;
						half <= 1'b1;
						state <= apu_audio_pkg::FS_STEP3;
					end
					apu_audio_pkg::FS_STEP3: begin
						quarter <= 1'b1;
						state <= apu_audio_pkg::FS_STEP4;
					end
					apu_audio_pkg::FS_STEP4: begin
						// Silent in 5-step mode.
						if (mode) begin
							state <= apu_audio_pkg::FS_STEP5;
						end else begin
							quarter <= 1'b1;
							half <= 1'b1;
							irq_tick <= 1'b1;
							state <= apu_audio_pkg::FS_STEP1;
						end
					end
					default: begin
						quarter <= 1'b1;
						half <= 1'b1;
						state <= apu_audio_pkg::FS_STEP1;
					end
				endcase
			end else if (phase) begin
				cnt <= cnt + 12'd1;
			end
		end
	end

	a_half_quarter: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		half |-> quarter);

endmodule

/* hdl/apu_pulse.sv */
`timescale 1ns/100ps

module apu_pulse (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      wr,
	input  apu_bus_pkg::chan_reg_t    reg_idx,
	input  apu_bus_pkg::apb_data_t    wdata,
	input  logic                      en,
	input  logic                      quarter,
	input  logic                      half,
	output apu_audio_pkg::sample_t    sample,
	output logic                      act
);

	localparam apu_audio_pkg::length_t LEN_TABLE [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	apu_audio_pkg::duty_t duty;
	logic halt;
	logic const_vol;
	apu_audio_pkg::sample_t vol;
	apu_audio_pkg::timer_t period;
	apu_audio_pkg::timer_t timer;
	apu_audio_pkg::length_t length;
	apu_audio_pkg::sample_t env_div;
	apu_audio_pkg::sample_t decay;
	logic [1:0] step;
	logic [3:0] pattern;
	logic wr3;

	assign wr3 = wr && (reg_idx == 2'd3);

	// Register 1 (sweep) is accepted and dropped.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			duty <= 2'd0;
			halt <= 1'b0;
			const_vol <= 1'b0;
			vol <= 4'd0;
			period <= 11'd0;
		end else if (wr) begin
			case (reg_idx)
				2'd0: begin
					duty <= wdata[7:6];
					halt <= wdata[5];
					const_vol <= wdata[4];
					vol <= wdata[3:0];
				end
				2'd2: period[7:0] <= wdata;
				2'd3: period[10:8] <= wdata[2:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer <= 11'd0;
			step <= 2'd0;
		end else if (wr3) begin
			step <= 2'd0;
		end else if (timer == 11'd0) begin
			timer <= period;
			step <= step + 2'd1;
		end else begin
			timer <= timer - 11'd1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			length <= 8'd0;
		end else if (!en) begin
			length <= 8'd0;
		end else if (wr3) begin
			length <= LEN_TABLE[wdata[7:3]];
		end else if (half && !halt && length != 8'd0) begin
			length <= length - 8'd1;
		end
	end

	// Envelope decays once per divider period, looping on halt.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			env_div <= 4'd0;
			decay <= 4'd0;
		end else if (wr3) begin
			env_div <= vol;
			decay <= 4'd15;
		end else if (quarter) begin
			if (env_div == 4'd0) begin
				env_div <= vol;
				if (decay != 4'd0) begin
					decay <= decay - 4'd1;
				end else if (halt) begin
					decay <= 4'd15;
				end
			end else begin
				env_div <= env_div - 4'd1;
			end
		end
	end

	always_comb begin
		case (duty)
			2'd0: pattern = 4'b0001;
			2'd1: pattern = 4'b0011;
			2'd2: pattern = 4'b0111;
			default: pattern = 4'b1110;
		endcase
	end

	assign act = (length != 8'd0);
	assign sample = (pattern[step] && act && period >= 11'd8) ?
		(const_vol ? vol : decay) : 4'd0;

endmodule

/* hdl/apu_mixer.sv */
`timescale 1ns/100ps
`include "apu_settings.svh"

module apu_mixer (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  apu_audio_pkg::sample_t sample0,
	input  apu_audio_pkg::sample_t sample1,
	output apu_audio_pkg::mix_t    audio
);

	logic [4:0] sum;
	logic [11:0] mix_wide;

	assign sum = {1'b0, sample0} + {1'b0, sample1};
	assign mix_wide = 12'(sum) << `APU_MIX_SHIFT;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			audio <= 8'd0;
		end else begin
			audio <= mix_wide[7:0];
		end
	end

	// Full-scale pair must still fit the output.
	a_no_wrap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		mix_wide[11:8] == 4'd0);

endmodule

/* hdl/apu.sv */
`timescale 1ns/100ps

module apu (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  apu_bus_pkg::apb_addr_t paddr,
	input  apu_bus_pkg::apb_data_t pwdata,
	output apu_bus_pkg::apb_data_t prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   irq,
	output apu_audio_pkg::mix_t    audio
);

	logic wr0;
	logic wr1;
	logic en0;
	logic en1;
	logic act0;
	logic act1;
	logic mode;
	logic restart;
	logic quarter;
	logic half;
	logic irq_tick;
	apu_bus_pkg::chan_reg_t reg_idx;
	apu_bus_pkg::apb_data_t wdata;
	apu_audio_pkg::sample_t sample0;
	apu_audio_pkg::sample_t sample1;

	apu_regs u_regs (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.irq_tick(irq_tick), .act0(act0), .act1(act1),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.wr0(wr0), .wr1(wr1), .reg_idx(reg_idx), .wdata(wdata),
		.en0(en0), .en1(en1), .mode(mode), .restart(restart), .irq(irq)
	);

	apu_frame_seq u_frame_seq (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.mode(mode), .restart(restart),
		.quarter(quarter), .half(half), .irq_tick(irq_tick)
	);

	apu_pulse u_pulse0 (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.wr(wr0), .reg_idx(reg_idx), .wdata(wdata), .en(en0),
		.quarter(quarter), .half(half),
		.sample(sample0), .act(act0)
	);

	apu_pulse u_pulse1 (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.wr(wr1), .reg_idx(reg_idx), .wdata(wdata), .en(en1),
		.quarter(quarter), .half(half),
		.sample(sample1), .act(act1)
	);

	apu_mixer u_mixer (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.sample0(sample0), .sample1(sample1),
		.audio(audio)
	);

endmodule

/* dv/apu_tb_tasks.svh */
`ifndef APU_TB_TASKS_SVH
`define APU_TB_TASKS_SVH

task automatic check_data(input string name, input apu_bus_pkg::apb_data_t got,
	input apu_bus_pkg::apb_data_t exp);
	if (got !== exp) begin
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s compare failed", name);
	end
endtask

task automatic check_mix(input string name, input apu_audio_pkg::mix_t got,
	input apu_audio_pkg::mix_t exp);
	if (got !== exp) begin
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s compare failed", name);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s compare failed", name);
	end
endtask

function automatic logic addr_mapped(input apu_bus_pkg::apb_addr_t addr);
	return (addr <= 5'h07) || (addr == `APU_ADDR_STATUS) || (addr == `APU_ADDR_FRAME);
endfunction

function automatic apu_bus_pkg::apb_data_t status_expect();
	return {1'b0, m_irq, 4'b0000, m_len[1] != 8'd0, m_len[0] != 8'd0};
endfunction

function automatic apu_audio_pkg::mix_t mix_level(input int level);
	return apu_audio_pkg::mix_t'(level << `APU_MIX_SHIFT);
endfunction

// Picks the allowed level that matches, else the full sum.
function automatic apu_audio_pkg::mix_t mix_expect(input apu_audio_pkg::mix_t got,
	input int v0, input int v1);
	if (got == mix_level(0)) return mix_level(0);
	if (got == mix_level(v0)) return mix_level(v0);
	if (got == mix_level(v1)) return mix_level(v1);
	return mix_level(v0 + v1);
endfunction

// Called 2 ns after a rising edge, returns 2 ns after the access edge.
task automatic bus_access(input logic write, input apu_bus_pkg::apb_addr_t addr,
	input apu_bus_pkg::apb_data_t data, output apu_bus_pkg::apb_data_t rdata);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = write;
	paddr = addr;
	pwdata = write ? data : 8'h00;
	@(posedge sys_clk);
	#2;
	penable = 1'b1;
	#5;
	rdata = prdata;
	if (!write) begin
		check_data("prdata", rdata, (addr == `APU_ADDR_STATUS) ? status_expect() : 8'h00);
	end
	check_bit("pslverr", pslverr, !addr_mapped(addr));
	check_bit("pready", pready, 1'b1);
	@(posedge sys_clk);
	#2;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_write(input apu_bus_pkg::apb_addr_t addr, input apu_bus_pkg::apb_data_t data);
	apu_bus_pkg::apb_data_t unused;
	bus_access(1'b1, addr, data, unused);
endtask

task automatic apb_read(input apu_bus_pkg::apb_addr_t addr, output apu_bus_pkg::apb_data_t data);
	bus_access(1'b0, addr, 8'h00, data);
endtask

`endif

/* dv/apu_tb.sv */
`timescale 1ns/100ps
`include "apu_settings.svh"

module apu_tb;

	localparam int unsigned SEQ_CYCLES = 8 * `APU_FRAME_STEP;
	localparam int unsigned TIMEOUT_CYCLES = 12 * SEQ_CYCLES;
	localparam apu_audio_pkg::length_t LENGTH_TABLE [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	logic sys_clk;
	logic sys_rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apu_bus_pkg::apb_addr_t paddr;
	apu_bus_pkg::apb_data_t pwdata;
	apu_bus_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic irq;
	apu_audio_pkg::mix_t audio;

	// Reference model state.
	int unsigned m_seq;
	logic m_mode;
	logic m_inhibit;
	logic m_irq;
	logic [1:0] m_en;
	logic [1:0] m_halt;
	apu_audio_pkg::length_t m_len [2];
	int unsigned cycles;

	`include "apu_tb_tasks.svh"

	apu uut (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.irq(irq), .audio(audio)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Steps land every 2*STEP cycles from a restart; ticks act one edge later.
	always @(posedge sys_clk or negedge sys_rst_n) begin : model_update
		int unsigned nxt;
		int unsigned k;
		int ch;
		logic half_ev;
		logic irq_ev;
		logic acc;
		if (!sys_rst_n) begin
			m_seq = 0;
			m_mode = 1'b0;
			m_inhibit = 1'b0;
			m_irq = 1'b0;
			m_en = 2'b00;
			m_halt = 2'b00;
			m_len[0] = 8'd0;
			m_len[1] = 8'd0;
		end else begin
			acc = psel && penable;
			nxt = m_seq + 1;
			k = (nxt - 1) / (2 * `APU_FRAME_STEP);
			half_ev = 1'b0;
			irq_ev = 1'b0;
			if (nxt > 1 && (nxt - 1) % (2 * `APU_FRAME_STEP) == 0) begin
				if (m_mode) begin
					half_ev = (k % 5 == 2) || (k % 5 == 0);
				end else begin
					half_ev = (k % 4 == 2) || (k % 4 == 0);
					irq_ev = (k % 4 == 0);
				end
			end
			for (ch = 0; ch < 2; ch++) begin
				if (!m_en[ch]) begin
					m_len[ch] = 8'd0;
				end else if (acc && pwrite && paddr == ch * 4 + 3) begin
					m_len[ch] = LENGTH_TABLE[pwdata[7:3]];
				end else if (half_ev && !m_halt[ch] && m_len[ch] != 8'd0) begin
					m_len[ch] = m_len[ch] - 8'd1;
				end
				if (acc && pwrite && paddr == ch * 4) begin
					m_halt[ch] = pwdata[5];
				end
			end
			if (acc && pwrite && paddr == `APU_ADDR_STATUS) begin
				m_en = pwdata[1:0];
			end
			if (acc && pwrite && paddr == `APU_ADDR_FRAME && pwdata[6]) begin
				m_irq = 1'b0;
			end else if (irq_ev && !m_inhibit) begin
				m_irq = 1'b1;
			end else if (acc && !pwrite && paddr == `APU_ADDR_STATUS) begin
				m_irq = 1'b0;
			end
			if (acc && pwrite && paddr == `APU_ADDR_FRAME) begin
				m_mode = pwdata[7];
				m_inhibit = pwdata[6];
				m_seq = 0;
			end else begin
				m_seq = nxt;
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	task automatic idle_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	task automatic run_to(input int unsigned target);
		while (m_seq < target) begin
			idle_cycle();
			check_bit("irq", irq, m_irq);
		end
	endtask

	initial begin : stimulus
		apu_bus_pkg::apb_data_t rd;
		apu_audio_pkg::sample_t v0;
		apu_audio_pkg::sample_t v1;
		int ch;
		int n;
		void'($urandom(54));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 5'h00;
		pwdata = 8'h00;
		sys_rst_n = 1'b0;
		repeat (4) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;

		// Status readback with random enables and lengths.
		repeat (8) begin
			apb_write(`APU_ADDR_STATUS, apu_bus_pkg::apb_data_t'($urandom));
			for (ch = 0; ch < 2; ch++) begin
				apb_write(5'(ch * 4), apu_bus_pkg::apb_data_t'($urandom));
				apb_write(5'(ch * 4 + 3), apu_bus_pkg::apb_data_t'($urandom));
			end
			apb_read(`APU_ADDR_STATUS, rd);
			ch = $urandom % 2;
			apb_write(`APU_ADDR_STATUS, {6'd0, m_en} & ~(8'd1 << ch));
			apb_read(`APU_ADDR_STATUS, rd);
			check_bit("act", rd[ch], 1'b0);
		end

		// Length expiry with short lengths of 2 or 4.
		apb_write(`APU_ADDR_STATUS, 8'h03);
		apb_write(`APU_ADDR_FRAME, 8'h40);
		for (ch = 0; ch < 2; ch++) begin
			apb_write(5'(ch * 4), {2'd2, 1'($urandom), 5'h1f});
			apb_write(5'(ch * 4 + 3), {($urandom % 2) ? 5'd3 : 5'd5, 3'd0});
		end
		while ((m_len[0] != 8'd0 && !m_halt[0]) || (m_len[1] != 8'd0 && !m_halt[1])) begin
			idle_cycle();
		end
		apb_read(`APU_ADDR_STATUS, rd);
		check_bit("act0", rd[0], m_halt[0]);
		check_bit("act1", rd[1], m_halt[1]);

		// Interrupt at the end of each 4-step sequence.
		apb_write(`APU_ADDR_FRAME, 8'h00);
		for (n = 1; n <= 2; n++) begin
			run_to(n * SEQ_CYCLES + 1);
			check_bit("irq", irq, 1'b1);
			apb_read(`APU_ADDR_STATUS, rd);
			check_bit("prdata[6]", rd[6], 1'b1);
			check_bit("irq", irq, 1'b0);
		end

		// 5-step mode, then inhibit.
		apb_write(`APU_ADDR_FRAME, 8'h80);
		run_to(20 * `APU_FRAME_STEP + 8);
		check_bit("irq", irq, 1'b0);
		apb_write(`APU_ADDR_FRAME, 8'h40);
		run_to(SEQ_CYCLES + 8);
		check_bit("irq", irq, 1'b0);
		apb_write(`APU_ADDR_FRAME, 8'h00);
		run_to(SEQ_CYCLES + 1);
		check_bit("irq", irq, 1'b1);
		apb_write(`APU_ADDR_FRAME, 8'h40);
		check_bit("irq", irq, 1'b0);

		// Mixer levels with halted channels at constant volume.
		v0 = $urandom;
		v1 = $urandom;
		apb_write(`APU_ADDR_STATUS, 8'h03);
		apb_write(5'h00, {2'($urandom), 2'b11, v0});
		apb_write(5'h02, 8'(8 + $urandom % 64));
		apb_write(5'h03, 8'h08);
		apb_write(5'h04, {2'($urandom), 2'b11, v1});
		apb_write(5'h06, 8'(8 + $urandom % 64));
		apb_write(5'h07, 8'h08);
		repeat (2) idle_cycle();
		repeat (400) begin
			idle_cycle();
			check_mix("audio", audio, mix_expect(audio, v0, v1));
		end
		apb_write(`APU_ADDR_STATUS, 8'h00);
		repeat (2) idle_cycle();
		repeat (100) begin
			idle_cycle();
			check_mix("audio", audio, 8'h00);
		end

		// Random addresses with pslverr checked on every access.
		repeat (40) begin
			if ($urandom % 2) begin
				apb_read(apu_bus_pkg::apb_addr_t'($urandom), rd);
			end else begin
				apb_write(apu_bus_pkg::apb_addr_t'($urandom), apu_bus_pkg::apb_data_t'($urandom));
			end
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hdl
+incdir+dv
hdl/apu_bus_pkg.sv
hdl/apu_audio_pkg.sv
hdl/apu_regs.sv
hdl/apu_frame_seq.sv
hdl/apu_pulse.sv
hdl/apu_mixer.sv
hdl/apu.sv
dv/apu_tb.sv
